// ==== wbuf_cfg_pkg.sv ====
/* AXI4-Lite register map of the weight buffer.
   8-bit byte addresses and 32-bit data, single beats only, strobes ignored */
`default_nettype none

package wbuf_cfg_pkg;

  localparam int unsigned AXIL_AW = 8;
  localparam int unsigned AXIL_DW = 32;
  localparam int unsigned AXIL_SW = AXIL_DW / 8;

  typedef struct packed {
    logic [AXIL_AW-1:0] aw_addr;
    logic               aw_valid;
    logic [AXIL_DW-1:0] w_data;
    logic [AXIL_SW-1:0] w_strb;
    logic               w_valid;
    logic               b_ready;
    logic [AXIL_AW-1:0] ar_addr;
    logic               ar_valid;
    logic               r_ready;
  } axil_req_t;

  typedef struct packed {
    logic               aw_ready;
    logic               w_ready;
    logic               b_valid;
    logic [1:0]         b_resp;
    logic               ar_ready;
    logic               r_valid;
    logic [AXIL_DW-1:0] r_data;
    logic [1:0]         r_resp;
  } axil_rsp_t;

  localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
  localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

  // register offsets
  localparam logic [AXIL_AW-1:0] REG_CTRL    = 8'h00; // write-only pulses
  localparam logic [AXIL_AW-1:0] REG_STATUS  = 8'h04;
  localparam logic [AXIL_AW-1:0] REG_ROW_MAP = 8'h08;
  localparam logic [AXIL_AW-1:0] REG_CMD     = 8'h0C; // commit staged line
  localparam logic [AXIL_AW-1:0] REG_LINE0   = 8'h10;
  localparam logic [AXIL_AW-1:0] REG_LINE1   = 8'h14;
  localparam logic [AXIL_AW-1:0] REG_LINE2   = 8'h18;
  localparam logic [AXIL_AW-1:0] REG_LINE3   = 8'h1C;

  localparam int unsigned CTRL_START_BIT     = 0;
  localparam int unsigned CTRL_CLEAR_BIT     = 1;
  localparam int unsigned STATUS_BUSY_BIT    = 0;
  localparam int unsigned STATUS_REFUSED_BIT = 1; // sticky, write 1 to clear

  localparam logic [7:0] ROW_MAP_RESET = 8'hE4; // identity

endpackage

`default_nettype wire

// ==== wbuf_data_pkg.sv ====
/* Geometry and data types of the weight buffer.
   The diagonal column wrap needs ROWS == COLS, each a power of two */
`default_nettype none

package wbuf_data_pkg;

  localparam int unsigned ROWS      = 4;
  localparam int unsigned COLS      = 4;
  localparam int unsigned ELMS      = 2;
  localparam int unsigned WORD_SIZE = 16;

  localparam int unsigned ROW_AW = $clog2(ROWS);
  localparam int unsigned COL_AW = $clog2(COLS);
  localparam int unsigned ELM_AW = $clog2(ELMS);

  // one buffer line, column c holds ELMS elements, element 0 lowest
  typedef logic [COLS-1:0][ELMS-1:0][WORD_SIZE-1:0] wbuf_line_t;

  // source row per output row
  typedef logic [ROWS-1:0][ROW_AW-1:0] row_map_t;

  // one element per output row
  typedef logic [ROWS-1:0][WORD_SIZE-1:0] rows_data_t;

  typedef struct packed {
    rows_data_t        rows_data;
    logic [COL_AW-1:0] col_offs;
    logic [ELM_AW-1:0] elm_idx;
    logic              last;     // final beat of a drain
  } wbuf_beat_t;

endpackage

`default_nettype wire

// ==== wbuf_regs.sv ====
/* AXI4-Lite register block. One write and one read in flight at most.
   CMD writes and clears are refused while a drain runs or is about to start;
   the sticky flag in STATUS records that, the response is still OKAY */
`timescale 1ns/1ns
`default_nettype none

module wbuf_regs (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  wbuf_cfg_pkg::axil_req_t           axil_req_i,
  output wbuf_cfg_pkg::axil_rsp_t           axil_rsp_o,
  input  logic                              busy_i,
  output logic                              start_o,
  output logic                              clear_o,
  output logic                              write_en_o,
  output logic [wbuf_data_pkg::ROW_AW-1:0]  write_addr_o,
  output wbuf_data_pkg::wbuf_line_t         wdata_o,
  output wbuf_data_pkg::row_map_t           row_map_o
);
  import wbuf_cfg_pkg::*;
  import wbuf_data_pkg::*;

  logic               wr_hs, rd_hs, busy_eff;
  logic               wr_ctrl, wr_status, wr_map, wr_cmd, wr_line, wr_ok;
  logic               rd_ok;
  logic [AXIL_DW-1:0] wdat, rd_word;
  logic [COL_AW-1:0]  line_idx;

  logic               b_valid_q, r_valid_q;
  logic [1:0]         b_resp_q, r_resp_q;
  logic [AXIL_DW-1:0] r_data_q;
  logic               start_q, clear_q, wen_q, refused_q;
  logic [ROW_AW-1:0]  waddr_q;
  row_map_t           row_map_q;
  wbuf_line_t         line_q;

  assign wdat     = axil_req_i.w_data;
  assign wr_hs    = axil_req_i.aw_valid & axil_req_i.w_valid & ~b_valid_q;
  assign rd_hs    = axil_req_i.ar_valid & ~r_valid_q;
  assign busy_eff = busy_i | start_q; // start issued, busy not yet up
  assign line_idx = axil_req_i.aw_addr[2 +: COL_AW];

  always_comb begin
    wr_ctrl   = 1'b0;
    wr_status = 1'b0;
    wr_map    = 1'b0;
    wr_cmd    = 1'b0;
    wr_line   = 1'b0;
    case (axil_req_i.aw_addr)
      REG_CTRL:    wr_ctrl = 1'b1;
      REG_STATUS:  wr_status = 1'b1;
      REG_ROW_MAP: wr_map = 1'b1;
      REG_CMD:     wr_cmd = 1'b1;
      REG_LINE0, REG_LINE1, REG_LINE2, REG_LINE3: wr_line = 1'b1;
      default: ;
    endcase
  end
  assign wr_ok = wr_ctrl | wr_status | wr_map | wr_cmd | wr_line;

  always_comb begin
    rd_ok   = 1'b1;
    rd_word = '0;
    case (axil_req_i.ar_addr)
      REG_CTRL, REG_CMD: rd_word = '0;
      REG_STATUS: begin
        rd_word[STATUS_BUSY_BIT]    = busy_i;
        rd_word[STATUS_REFUSED_BIT] = refused_q;
      end
      REG_ROW_MAP: rd_word[ROWS*ROW_AW-1:0] = row_map_q;
      REG_LINE0, REG_LINE1, REG_LINE2, REG_LINE3: begin
        rd_word = line_q[axil_req_i.ar_addr[2 +: COL_AW]];
      end
      default: rd_ok = 1'b0;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      b_valid_q <= 1'b0;
      b_resp_q  <= AXI_RESP_OKAY;
      r_valid_q <= 1'b0;
      r_resp_q  <= AXI_RESP_OKAY;
      start_q   <= 1'b0;
      clear_q   <= 1'b0;
      wen_q     <= 1'b0;
      refused_q <= 1'b0;
      row_map_q <= ROW_MAP_RESET;
    end else begin
      start_q <= wr_hs & wr_ctrl & wdat[CTRL_START_BIT] & ~busy_eff;
      clear_q <= wr_hs & wr_ctrl & wdat[CTRL_CLEAR_BIT] & ~busy_eff;
      wen_q   <= wr_hs & wr_cmd & ~busy_eff;

      if (wr_hs) begin
        b_valid_q <= 1'b1;
        b_resp_q  <= wr_ok ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
      end else if (axil_req_i.b_ready) begin
        b_valid_q <= 1'b0;
      end

      if (rd_hs) begin
        r_valid_q <= 1'b1;
        r_resp_q  <= rd_ok ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
      end else if (axil_req_i.r_ready) begin
        r_valid_q <= 1'b0;
      end

      if (wr_hs && wr_map) row_map_q <= wdat[ROWS*ROW_AW-1:0];
      if (wr_hs && wr_status && wdat[STATUS_REFUSED_BIT]) refused_q <= 1'b0;
      if (wr_hs && busy_eff && (wr_cmd || (wr_ctrl && wdat[CTRL_CLEAR_BIT]))) begin
        refused_q <= 1'b1;
      end
    end
  end

  // staging line and read data, no reset
  always_ff @(posedge clk_i) begin
    if (wr_hs && wr_line) line_q[line_idx] <= wdat;
    if (wr_hs && wr_cmd) waddr_q <= wdat[ROW_AW-1:0];
    if (rd_hs) r_data_q <= rd_word;
  end

  always_comb begin
    axil_rsp_o.aw_ready = wr_hs;
    axil_rsp_o.w_ready  = wr_hs;
    axil_rsp_o.b_valid  = b_valid_q;
    axil_rsp_o.b_resp   = b_resp_q;
    axil_rsp_o.ar_ready = ~r_valid_q;
    axil_rsp_o.r_valid  = r_valid_q;
    axil_rsp_o.r_data   = r_data_q;
    axil_rsp_o.r_resp   = r_resp_q;
  end

  assign start_o      = start_q;
  assign clear_o      = clear_q;
  assign write_en_o   = wen_q;
  assign write_addr_o = waddr_q;
  assign wdata_o      = line_q; // line is stable while write_en is up
  assign row_map_o    = row_map_q;

  a_wen_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(write_en_o) |-> !busy_i);

  a_b_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    b_valid_q && !axil_req_i.b_ready |=> b_valid_q);

endmodule

`default_nettype wire

// ==== wbuf_scm.sv ====
/* Flip-flop weight buffer, ROWS lines of COLS x ELMS words.
   Read addresses are sampled on read_en_i, data follows one cycle later and
   holds until the next read. Output row r reads column (offset - r) mod COLS */
`timescale 1ns/1ns
`default_nettype none

module wbuf_scm (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              clear_i,
  input  logic                              write_en_i,
  input  logic [wbuf_data_pkg::ROW_AW-1:0]  write_addr_i,
  input  wbuf_data_pkg::wbuf_line_t         wdata_i,
  input  logic                              read_en_i,
  input  logic [wbuf_data_pkg::ELM_AW-1:0]  elm_idx_i,
  input  logic [wbuf_data_pkg::COL_AW-1:0]  col_offs_i,
  input  wbuf_data_pkg::row_map_t           rows_read_addr_i,
  output wbuf_data_pkg::rows_data_t         rdata_o
);
  import wbuf_data_pkg::*;

  wbuf_line_t                   buffer_q [ROWS];
  logic [ELM_AW-1:0]            elm_idx_q;
  logic [COL_AW-1:0]            col_offs_q;
  row_map_t                     row_addr_q;
  logic [ROWS-1:0][COL_AW-1:0]  col_sel;

  if (ROWS != COLS) begin : gen_geom_check
    $error("diagonal addressing needs ROWS == COLS");
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // storage
  for (genvar r = 0; r < ROWS; r++) begin : gen_rows
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        buffer_q[r] <= '0;
      end else if (clear_i) begin
        buffer_q[r] <= '0;
      end else if (write_en_i && write_addr_i == ROW_AW'(r)) begin
        buffer_q[r] <= wdata_i;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read side
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      elm_idx_q  <= '0;
      col_offs_q <= '0;
      row_addr_q <= '0;
    end else if (read_en_i) begin
      elm_idx_q  <= elm_idx_i;
      col_offs_q <= col_offs_i;
      row_addr_q <= rows_read_addr_i;
    end
  end

  for (genvar r = 0; r < ROWS; r++) begin : gen_rd
    assign col_sel[r] = col_offs_q - COL_AW'(r); // wraps mod COLS
    assign rdata_o[r] = buffer_q[row_addr_q[r]][col_sel[r]][elm_idx_q];
  end

  a_wr_clr_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(write_en_i && clear_i));

endmodule

`default_nettype wire

// ==== wbuf_drain_seq.sv ====
/* Drain sequencer. Walks col_offs 0..COLS-1 outer, elm_idx inner, one read
   per beat. At most one read in flight plus one beat held; the next read is
   issued in the cycle the held beat transfers */
`timescale 1ns/1ns
`default_nettype none

module wbuf_drain_seq (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              start_i,
  input  wbuf_data_pkg::row_map_t           row_map_i,
  output logic                              busy_o,
  output logic                              read_en_o,
  output logic [wbuf_data_pkg::ELM_AW-1:0]  elm_idx_o,
  output logic [wbuf_data_pkg::COL_AW-1:0]  col_offs_o,
  output wbuf_data_pkg::row_map_t           rows_read_addr_o,
  input  wbuf_data_pkg::rows_data_t         rdata_i,
  output wbuf_data_pkg::wbuf_beat_t         beat_o,
  output logic                              beat_valid_o,
  input  logic                              beat_ready_i
);
  import wbuf_data_pkg::*;

  logic              busy_q, first_q, beat_valid_q, beat_last_q;
  logic              start_acc, xfer, elm_wrap, last_rd;
  logic [ELM_AW-1:0] elm_q, beat_elm_q;
  logic [COL_AW-1:0] col_q, beat_col_q;
  row_map_t          map_q;

  assign start_acc = start_i & ~busy_q; // start while busy is dropped
  assign xfer      = beat_valid_q & beat_ready_i;
  assign elm_wrap  = (elm_q == ELM_AW'(ELMS-1));
  assign last_rd   = elm_wrap && (col_q == COL_AW'(COLS-1));
  assign read_en_o = first_q | (xfer & ~beat_last_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q       <= 1'b0;
      first_q      <= 1'b0;
      beat_valid_q <= 1'b0;
      beat_last_q  <= 1'b0;
      beat_col_q   <= '0;
      beat_elm_q   <= '0;
      col_q        <= '0;
      elm_q        <= '0;
    end else begin
      first_q <= start_acc;
      if (start_acc) begin
        busy_q <= 1'b1;
        col_q  <= '0;
        elm_q  <= '0;
      end else if (xfer && beat_last_q) begin
        busy_q <= 1'b0;
      end

      if (read_en_o) begin
        beat_valid_q <= 1'b1; // data of this read shows next cycle
        beat_col_q   <= col_q;
        beat_elm_q   <= elm_q;
        beat_last_q  <= last_rd;
        elm_q        <= elm_wrap ? '0 : elm_q + 1'b1;
        if (elm_wrap) col_q <= col_q + 1'b1;
      end else if (xfer) begin
        beat_valid_q <= 1'b0;
      end
    end
  end

  // row map is held for the whole drain
  always_ff @(posedge clk_i) begin
    if (start_acc) map_q <= row_map_i;
  end

  assign busy_o           = busy_q;
  assign elm_idx_o        = elm_q;
  assign col_offs_o       = col_q;
  assign rows_read_addr_o = map_q;

  always_comb begin
    beat_o.rows_data = rdata_i; // buffer holds rdata until the next read
    beat_o.col_offs  = beat_col_q;
    beat_o.elm_idx   = beat_elm_q;
    beat_o.last      = beat_last_q;
  end
  assign beat_valid_o = beat_valid_q;

  a_beat_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    beat_valid_o && !beat_ready_i |=> beat_valid_o && $stable(beat_o));

  a_no_rd_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    beat_valid_o && !beat_ready_i |-> !read_en_o);

endmodule

`default_nettype wire

// ==== wbuf_top.sv ====
/* Weight buffer top: AXI4-Lite register block, flip-flop buffer and drain
   sequencer. Beats leave on a valid/ready port with no skid buffer */
`timescale 1ns/1ns
`default_nettype none

module wbuf_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  wbuf_cfg_pkg::axil_req_t     axil_req_i,
  output wbuf_cfg_pkg::axil_rsp_t     axil_rsp_o,
  output wbuf_data_pkg::wbuf_beat_t   beat_o,
  output logic                        beat_valid_o,
  input  logic                        beat_ready_i
);
  import wbuf_data_pkg::*;

  logic              busy, start, clear, write_en, read_en;
  logic [ROW_AW-1:0] write_addr;
  logic [ELM_AW-1:0] elm_idx;
  logic [COL_AW-1:0] col_offs;
  wbuf_line_t        wdata;
  row_map_t          row_map, rows_read_addr;
  rows_data_t        rdata;

  wbuf_regs i_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .axil_req_i   (axil_req_i),
    .axil_rsp_o   (axil_rsp_o),
    .busy_i       (busy),
    .start_o      (start),
    .clear_o      (clear),
    .write_en_o   (write_en),
    .write_addr_o (write_addr),
    .wdata_o      (wdata),
    .row_map_o    (row_map)
  );

  wbuf_scm i_scm (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .clear_i          (clear),
    .write_en_i       (write_en),
    .write_addr_i     (write_addr),
    .wdata_i          (wdata),
    .read_en_i        (read_en),
    .elm_idx_i        (elm_idx),
    .col_offs_i       (col_offs),
    .rows_read_addr_i (rows_read_addr),
    .rdata_o          (rdata)
  );

  wbuf_drain_seq i_drain_seq (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .start_i          (start),
    .row_map_i        (row_map),
    .busy_o           (busy),
    .read_en_o        (read_en),
    .elm_idx_o        (elm_idx),
    .col_offs_o       (col_offs),
    .rows_read_addr_o (rows_read_addr),
    .rdata_i          (rdata),
    .beat_o           (beat_o),
    .beat_valid_o     (beat_valid_o),
    .beat_ready_i     (beat_ready_i)
  );

endmodule

`default_nettype wire

// ==== tb_wbuf_top.sv ====
/* Testbench for the weight buffer top level.
   Host writes and reads go over AXI4-Lite with b_ready and r_ready held high.
   Beats are sampled on the falling edge and checked against a buffer model */
`timescale 1ns/1ns
`default_nettype none

module tb_wbuf_top;
  import wbuf_cfg_pkg::*;
  import wbuf_data_pkg::*;

  localparam int TIMEOUT = 300;         // cycles per wait
  localparam int NBEATS  = COLS * ELMS;

  logic       clk_i = 1'b0;
  logic       rst_ni;
  axil_req_t  axil_req;
  axil_rsp_t  axil_rsp;
  wbuf_beat_t beat;
  logic       beat_valid;
  logic       beat_ready = 1'b0;

  int         seed = 32'hee05;
  int         errors = 0;
  int         checks = 0;
  int         ready_mode = 0;           // 0 always ready, 1 random, 2 stalled
  logic [WORD_SIZE-1:0] model [ROWS][COLS][ELMS];
  wbuf_beat_t beats[$];
  wbuf_beat_t ref_beats[$];
  wbuf_beat_t held_beat;
  logic       held = 1'b0;

  wbuf_top DUT (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .axil_req_i   (axil_req),
    .axil_rsp_o   (axil_rsp),
    .beat_o       (beat),
    .beat_valid_o (beat_valid),
    .beat_ready_i (beat_ready)
  );

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    case (ready_mode)
      0: beat_ready <= 1'b1;
      1: beat_ready <= (($unsigned($random(seed)) % 10) < 7); // about 70 percent
      default: beat_ready <= 1'b0;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // compare tasks

  task automatic check_beat(input string name, input wbuf_beat_t exp, input wbuf_beat_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED t=%0t %s exp=%h act=%h", $time, name, exp, act);
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] exp_resp,
                            input logic [31:0] exp_data, input logic [1:0] act_resp,
                            input logic [31:0] act_data);
    checks++;
    if (exp_resp !== act_resp || exp_data !== act_data) begin
      errors++;
      $display("CHECK FAILED t=%0t %s exp=%h/%h act=%h/%h", $time, name,
               exp_resp, exp_data, act_resp, act_data);
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    $display("checks %0d, errors %0d", checks, errors + 1);
    $display("Test FAILED");
    $finish;
  endtask

  // beat monitor, a transfer happens on the next rising edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (held) begin
        if (!beat_valid) begin
          errors++;
          $display("beat_valid_o dropped at %0t while a beat was held", $time);
        end else begin
          check_beat("beat_o held", held_beat, beat);
        end
      end
      held = 1'b0;
      if (beat_valid) begin
        if (beat_ready) begin
          beats.push_back(beat);
        end else begin
          held      = 1'b1;
          held_beat = beat;
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // AXI4-Lite host

  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    int cnt;
    @(posedge clk_i);
    axil_req.aw_addr  <= addr;
    axil_req.w_data   <= data;
    axil_req.w_strb   <= 4'hF;
    axil_req.aw_valid <= 1'b1;
    axil_req.w_valid  <= 1'b1;
    cnt = 0;
    @(negedge clk_i);
    while (!axil_rsp.aw_ready) begin
      if (cnt == TIMEOUT) abort_on_timeout("aw_ready");
      cnt++;
      @(negedge clk_i);
    end
    if (!axil_rsp.w_ready) begin
      errors++;
      $display("w_ready low at %0t while aw_ready was high", $time);
    end
    @(posedge clk_i);
    axil_req.aw_valid <= 1'b0;
    axil_req.w_valid  <= 1'b0;
    cnt = 0;
    @(negedge clk_i);
    while (!axil_rsp.b_valid) begin
      if (cnt == TIMEOUT) abort_on_timeout("b_valid");
      cnt++;
      @(negedge clk_i);
    end
    resp = axil_rsp.b_resp;
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [1:0] resp,
                           output logic [31:0] data);
    int cnt;
    @(posedge clk_i);
    axil_req.ar_addr  <= addr;
    axil_req.ar_valid <= 1'b1;
    cnt = 0;
    @(negedge clk_i);
    while (!axil_rsp.ar_ready) begin
      if (cnt == TIMEOUT) abort_on_timeout("ar_ready");
      cnt++;
      @(negedge clk_i);
    end
    @(posedge clk_i);
    axil_req.ar_valid <= 1'b0;
    cnt = 0;
    @(negedge clk_i);
    while (!axil_rsp.r_valid) begin
      if (cnt == TIMEOUT) abort_on_timeout("r_valid");
      cnt++;
      @(negedge clk_i);
    end
    resp = axil_rsp.r_resp;
    data = axil_rsp.r_data;
  endtask

  task automatic write_ok(input logic [7:0] addr, input logic [31:0] data);
    logic [1:0] resp;
    axil_write(addr, data, resp);
    check_resp($sformatf("b_resp @%h", addr), AXI_RESP_OKAY, 32'h0, resp, 32'h0);
  endtask

  task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp_data,
                             input logic [1:0] exp_resp);
    logic [1:0]  resp;
    logic [31:0] data;
    axil_read(addr, resp, data);
    check_resp($sformatf("r_resp/r_data @%h", addr), exp_resp, exp_data, resp, data);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // buffer model and drains

  task automatic fill_buffer();
    logic [31:0] w;
    for (int row = 0; row < ROWS; row++) begin
      for (int k = 0; k < COLS; k++) begin
        w = $random(seed);
        model[row][k][0] = w[15:0];
        model[row][k][1] = w[31:16];
        write_ok(REG_LINE0 + 8'(4 * k), w);
      end
      write_ok(REG_CMD, 32'(row));
    end
  endtask

  task automatic wait_drain_end();
    int          cnt;
    logic [1:0]  resp;
    logic [31:0] data;
    cnt = 0;
    while (beats.size() < NBEATS) begin
      if (cnt == TIMEOUT) abort_on_timeout("drain beats");
      cnt++;
      @(negedge clk_i);
    end
    cnt  = 0;
    data = 32'h1;
    while (data[STATUS_BUSY_BIT]) begin
      if (cnt == TIMEOUT) abort_on_timeout("busy to fall");
      cnt++;
      axil_read(REG_STATUS, resp, data);
    end
    if (beats.size() != NBEATS) begin
      errors++;
      $display("drain gave %0d beats instead of %0d", beats.size(), NBEATS);
    end
  endtask

  task automatic run_drain(input int mode);
    beats.delete();
    ready_mode = mode;
    write_ok(REG_CTRL, 32'h1);
    wait_drain_end();
  endtask

  // row r of beat (o, e) reads model[map[r]][(o - r) mod COLS][e]
  task automatic compare_drain(input row_map_t map);
    wbuf_beat_t exp;
    int         o;
    int         e;
    for (int i = 0; i < NBEATS && i < beats.size(); i++) begin
      o = i / ELMS;
      e = i % ELMS;
      for (int r = 0; r < ROWS; r++) begin
        exp.rows_data[r] = model[map[r]][(o - r + COLS) % COLS][e];
      end
      exp.col_offs = COL_AW'(o);
      exp.elm_idx  = ELM_AW'(e);
      exp.last     = (i == NBEATS - 1);
      check_beat($sformatf("beat_o #%0d", i), exp, beats[i]);
    end
  endtask

  task automatic report_test(input int num, input string title, input int err_before);
    $display("test %0d %s: %s", num, title, (errors == err_before) ? "passed" : "failed");
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    int          err0;
    int          cnt;
    logic [31:0] w;
    row_map_t    map;
    rst_ni = 1'b0;
    axil_req = '0;
    axil_req.b_ready = 1'b1;
    axil_req.r_ready = 1'b1;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;

    err0 = errors;
    fill_buffer();
    run_drain(0);
    compare_drain(8'hE4);
    ref_beats = beats;
    report_test(1, "fill and drain, identity map", err0);

    err0 = errors;
    w   = $random(seed);
    map = w[7:0];
    write_ok(REG_ROW_MAP, {24'h0, map});
    read_expect(REG_ROW_MAP, {24'h0, map}, AXI_RESP_OKAY);
    run_drain(0);
    compare_drain(map);
    report_test(2, "row map permutation", err0);

    err0 = errors;
    write_ok(REG_ROW_MAP, 32'hE4);
    run_drain(1);
    compare_drain(8'hE4);
    for (int i = 0; i < NBEATS && i < beats.size(); i++) begin
      check_beat($sformatf("beat_o vs test 1 #%0d", i), ref_beats[i], beats[i]);
    end
    report_test(3, "back-pressure", err0);

    err0 = errors;
    write_ok(REG_CTRL, 32'h2);
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        model[r][c][0] = '0;
        model[r][c][1] = '0;
      end
    end
    run_drain(0);
    compare_drain(8'hE4);
    report_test(4, "clear", err0);

    err0 = errors;
    fill_buffer();
    beats.delete();
    ready_mode = 2; // hold the first beat so the drain stays busy
    w = $random(seed);
    write_ok(REG_LINE2, w);
    write_ok(REG_CTRL, 32'h1);
    cnt = 0;
    while (!beat_valid) begin
      if (cnt == TIMEOUT) abort_on_timeout("first beat_valid");
      cnt++;
      @(negedge clk_i);
    end
    read_expect(REG_STATUS, 32'h1, AXI_RESP_OKAY);
    write_ok(REG_CMD, 32'h0); // refused
    read_expect(REG_STATUS, 32'h3, AXI_RESP_OKAY);
    read_expect(REG_LINE2, w, AXI_RESP_OKAY);
    read_expect(8'h20, 32'h0, AXI_RESP_SLVERR);
    ready_mode = 1;
    wait_drain_end();
    compare_drain(8'hE4);
    read_expect(REG_STATUS, 32'h2, AXI_RESP_OKAY);
    write_ok(REG_STATUS, 32'h2);
    read_expect(REG_STATUS, 32'h0, AXI_RESP_OKAY);
    run_drain(0);
    compare_drain(8'hE4);
    report_test(5, "refused writes and errors", err0);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== wbuf_top.f ====
wbuf_cfg_pkg.sv
wbuf_data_pkg.sv
wbuf_regs.sv
wbuf_scm.sv
wbuf_drain_seq.sv
wbuf_top.sv
tb_wbuf_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the weight buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f wbuf_top.f --top-module tb_wbuf_top -o sim_wbuf
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_wbuf)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test OK"; then
  exit 0
else
  exit 1
fi
